/* design/axi_pkg.sv */
`default_nettype none

package axi_pkg;

    localparam int ADDR_W = 32;
    localparam int LEN_W  = 4;   // 16-beat bursts at most
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [LEN_W-1:0]  axi_len_t;   // zero-based beat count
    typedef logic [1:0]        axi_resp_t;
    typedef logic [DATA_W-1:0] word_t;
    typedef logic [STRB_W-1:0] strb_t;

    // read response codes
    localparam axi_resp_t RESP_OKAY   = 2'b00;
    localparam axi_resp_t RESP_SLVERR = 2'b10;

endpackage

`default_nettype wire

/* design/dma_pkg.sv */
`default_nettype none

package dma_pkg;

    localparam int BLEN_W = 12;

    typedef logic [BLEN_W-1:0] byte_cnt_t;
    typedef logic [1:0]        lane_t;      // byte lane within a 32-bit word

    // one split burst, as queued between splitter and reader
    typedef struct packed {
        axi_pkg::addr_t    addr;        // word aligned
        axi_pkg::axi_len_t len;         // words minus one
        logic              first;       // first burst of its command
        logic              last;        // last burst of its command
        lane_t             start_off;   // command address mod 4
        lane_t             end_off;     // command end mod 4, 0 = full word
    } burst_t;

    // what the reader keeps per in-flight burst
    typedef struct packed {
        logic  first;
        logic  last;
        lane_t start_off;
        lane_t end_off;
    } burst_tag_t;

    function automatic burst_tag_t burst_to_tag(input burst_t b);
        burst_tag_t t;
        t.first     = b.first;
        t.last      = b.last;
        t.start_off = b.start_off;
        t.end_off   = b.end_off;
        return t;
    endfunction

endpackage

`default_nettype wire

/* design/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
    parameter int  DEPTH  = 4,
    parameter type item_t = logic
) (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   push,
    input  item_t                  push_data,
    output logic                   full,

    input  logic                   pop,
    output item_t                  pop_data,
    output logic                   empty,

    output logic [$clog2(DEPTH):0] free
);

    localparam int AW = $clog2(DEPTH);
    localparam int CW = AW + 1;

    item_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;

    logic          do_push;
    logic          do_pop;

    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full     = count == CW'(DEPTH);
    assign empty    = count == '0;
    assign free     = CW'(DEPTH) - count;
    assign pop_data = mem[rd_ptr];

    // pointers wrap by hand so DEPTH need not be a power of two
    function automatic logic [AW-1:0] ptr_inc(input logic [AW-1:0] p);
        if (p == AW'(DEPTH - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

endmodule

`default_nettype wire

/* design/dma_cmd_split.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_cmd_split (
    input  logic               clk,
    input  logic               rst,

    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  axi_pkg::addr_t     cmd_addr,
    input  dma_pkg::byte_cnt_t cmd_bytes,

    output logic               burst_valid,
    input  logic               burst_ready,
    output dma_pkg::burst_t    burst
);

    import axi_pkg::*;
    import dma_pkg::*;

    localparam int WORD_AW = ADDR_W - 2;    // word index width
    localparam int BLK_W   = WORD_AW - LEN_W;

    logic               active;
    logic [WORD_AW-1:0] cur_word;           // next word to request
    logic [WORD_AW-1:0] last_word;          // final word of the command
    logic               first_flag;
    lane_t              start_off;
    lane_t              end_off;

    addr_t              cmd_end;            // address of the final byte
    logic               cmd_take;
    logic               burst_take;
    logic               last_burst;
    axi_len_t           cur_len;
    logic [BLK_W-1:0]   next_block;

    assign cmd_end    = cmd_addr + {{(ADDR_W-BLEN_W){1'b0}}, cmd_bytes} - 1'b1;
    assign cmd_take   = cmd_valid && cmd_ready;
    assign burst_take = burst_valid && burst_ready;

    // final burst once the end word sits in the current aligned block
    assign last_burst = cur_word[WORD_AW-1:LEN_W] == last_word[WORD_AW-1:LEN_W];

    always_comb begin
        if (last_burst) begin
            cur_len = last_word[LEN_W-1:0] - cur_word[LEN_W-1:0];
        end else begin
            cur_len = ~cur_word[LEN_W-1:0];    // run up to the block boundary
        end
    end

    assign next_block = cur_word[WORD_AW-1:LEN_W] + 1'b1;

    assign cmd_ready   = !active;
    assign burst_valid = active;

    always_comb begin
        burst.addr      = {cur_word, 2'b00};
        burst.len       = cur_len;
        burst.first     = first_flag;
        burst.last      = last_burst;
        burst.start_off = start_off;
        burst.end_off   = end_off;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
        end else if (cmd_take) begin
            active <= 1'b1;
        end else if (burst_take && last_burst) begin
            active <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_take) begin
            cur_word   <= cmd_addr[ADDR_W-1:2];
            last_word  <= cmd_end[ADDR_W-1:2];
            first_flag <= 1'b1;
            start_off  <= cmd_addr[1:0];
            end_off    <= cmd_addr[1:0] + cmd_bytes[1:0];  // wraps to 0 on a full word
        end else if (burst_take) begin
            cur_word   <= {next_block, {LEN_W{1'b0}}};
            first_flag <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* design/axi_burst_reader.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_burst_reader #(
    parameter int MAX_OUT = 8,
    parameter int FREE_W  = 9
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               halt,
    output logic               busy,
    output logic               error,
    output logic               cmd_done,

    input  logic               q_valid,
    output logic               q_ready,
    input  dma_pkg::burst_t    q_burst,

    output logic               ar_valid,
    input  logic               ar_ready,
    output axi_pkg::addr_t     ar_addr,
    output axi_pkg::axi_len_t  ar_len,

    input  logic               r_valid,
    output logic               r_ready,
    input  axi_pkg::word_t     r_data,
    input  axi_pkg::axi_resp_t r_resp,
    input  logic               r_last,

    output logic               out_valid,
    input  logic               out_ready,
    output axi_pkg::word_t     out_data,
    output axi_pkg::strb_t     out_strb,
    output logic               out_last,
    input  logic [FREE_W-1:0]  out_free
);

    import axi_pkg::*;
    import dma_pkg::*;

    logic              take;
    logic              r_hs;
    logic              deliver;
    logic              bad_resp;

    logic [FREE_W-1:0] reserved;        // words promised but not yet delivered
    logic [FREE_W-1:0] usable;
    logic [FREE_W-1:0] burst_words;
    logic              space_ok;

    logic              tag_full;
    logic              tag_empty;
    burst_tag_t        head_tag;

    logic              beat_first;      // next r beat opens a burst
    logic              beat_cmd_last;
    strb_t             beat_strb;

    assign r_hs     = r_valid && r_ready;
    assign deliver  = out_valid && out_ready;
    assign bad_resp = r_resp != RESP_OKAY;

    // reserve a full-length burst worth of room before issuing anything
    assign usable      = out_free - reserved;
    assign space_ok    = |usable[FREE_W-1:LEN_W];
    assign burst_words = FREE_W'(q_burst.len) + 1'b1;

    assign q_ready = !ar_valid && !halt && !error && !tag_full && space_ok;
    assign take    = q_valid && q_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            reserved <= '0;
        end else begin
            reserved <= reserved + (take ? burst_words : '0) - FREE_W'(deliver);
        end
    end

    // in-flight tags, one per issued burst, retired on r_last
    sync_fifo #(
        .DEPTH  (MAX_OUT),
        .item_t (burst_tag_t)
    ) u_tag_fifo (
        .clk       (clk),
        .rst       (rst),
        .push      (take),
        .push_data (burst_to_tag(q_burst)),
        .full      (tag_full),
        .pop       (r_hs && r_last),
        .pop_data  (head_tag),
        .empty     (tag_empty),
        .free      ()
    );

    assign busy = !tag_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            ar_valid <= 1'b0;
        end else if (take) begin
            ar_valid <= 1'b1;
        end else if (ar_ready) begin
            ar_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            ar_addr <= q_burst.addr;
            ar_len  <= q_burst.len;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            beat_first <= 1'b1;
        end else if (r_hs) begin
            beat_first <= r_last;
        end
    end

    assign beat_cmd_last = r_last && head_tag.last;

    // trim the partial words at either end of the command
    always_comb begin
        beat_strb = '1;
        if (beat_first && head_tag.first) begin
            beat_strb = strb_t'(4'hf << head_tag.start_off);
        end
        if (beat_cmd_last && head_tag.end_off != 2'd0) begin
            beat_strb = beat_strb & ~strb_t'(4'hf << head_tag.end_off);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            error <= 1'b0;
        end else if (r_hs && bad_resp) begin
            error <= 1'b1;      // sticky until reset
        end
    end

    assign r_ready = out_ready || !out_valid;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (r_hs) begin
            out_valid <= !error && !bad_resp;   // drop the bad beat and all after it
            out_last  <= beat_cmd_last;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (r_hs) begin
            out_data <= r_data;
            out_strb <= beat_strb;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cmd_done <= 1'b0;
        end else begin
            cmd_done <= deliver && out_last;
        end
    end

endmodule

`default_nettype wire

/* design/dma_read.sv */
`timescale 1ns/1ps
`default_nettype none

module dma_read #(
    parameter int MAX_OUT     = 8,
    parameter int QUEUE_DEPTH = 4,
    parameter int FREE_W      = 9     // at least LEN_W + 1
) (
    input  logic               clk,
    input  logic               rst,

    input  logic               cmd_valid,
    output logic               cmd_ready,
    input  axi_pkg::addr_t     cmd_addr,
    input  dma_pkg::byte_cnt_t cmd_bytes,

    output logic               ar_valid,
    input  logic               ar_ready,
    output axi_pkg::addr_t     ar_addr,
    output axi_pkg::axi_len_t  ar_len,

    input  logic               r_valid,
    output logic               r_ready,
    input  axi_pkg::word_t     r_data,
    input  axi_pkg::axi_resp_t r_resp,
    input  logic               r_last,

    output logic               out_valid,
    input  logic               out_ready,
    output axi_pkg::word_t     out_data,
    output axi_pkg::strb_t     out_strb,
    output logic               out_last,
    input  logic [FREE_W-1:0]  out_free,

    input  logic               halt,
    output logic               busy,
    output logic               error,
    output logic               cmd_done
);

    import dma_pkg::*;

    logic   burst_valid;
    logic   burst_ready;
    burst_t burst;

    logic   q_valid;
    logic   q_ready;
    logic   q_full;
    logic   q_empty;
    burst_t q_burst;

    assign burst_ready = !q_full;
    assign q_valid     = !q_empty;

    dma_cmd_split u_split (
        .clk         (clk),
        .rst         (rst),
        .cmd_valid   (cmd_valid),
        .cmd_ready   (cmd_ready),
        .cmd_addr    (cmd_addr),
        .cmd_bytes   (cmd_bytes),
        .burst_valid (burst_valid),
        .burst_ready (burst_ready),
        .burst       (burst)
    );

    // burst queue between splitter and reader
    sync_fifo #(
        .DEPTH  (QUEUE_DEPTH),
        .item_t (burst_t)
    ) u_burst_q (
        .clk       (clk),
        .rst       (rst),
        .push      (burst_valid),
        .push_data (burst),
        .full      (q_full),
        .pop       (q_ready),
        .pop_data  (q_burst),
        .empty     (q_empty),
        .free      ()
    );

    axi_burst_reader #(
        .MAX_OUT (MAX_OUT),
        .FREE_W  (FREE_W)
    ) u_reader (
        .clk       (clk),
        .rst       (rst),
        .halt      (halt),
        .busy      (busy),
        .error     (error),
        .cmd_done  (cmd_done),
        .q_valid   (q_valid),
        .q_ready   (q_ready),
        .q_burst   (q_burst),
        .ar_valid  (ar_valid),
        .ar_ready  (ar_ready),
        .ar_addr   (ar_addr),
        .ar_len    (ar_len),
        .r_valid   (r_valid),
        .r_ready   (r_ready),
        .r_data    (r_data),
        .r_resp    (r_resp),
        .r_last    (r_last),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_data  (out_data),
        .out_strb  (out_strb),
        .out_last  (out_last),
        .out_free  (out_free)
    );

endmodule

`default_nettype wire

/* tb/axi_mem_model.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_model #(
    parameter logic [31:0]    SEED     = 32'h1,
    parameter axi_pkg::word_t PATTERN  = 32'h0,
    parameter axi_pkg::addr_t ERR_ADDR = 32'h0
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               ar_valid,
    output logic               ar_ready,
    input  axi_pkg::addr_t     ar_addr,
    input  axi_pkg::axi_len_t  ar_len,
    output logic               r_valid,
    input  logic               r_ready,
    output axi_pkg::word_t     r_data,
    output axi_pkg::axi_resp_t r_resp,
    output logic               r_last
);

    import axi_pkg::*;

    logic [31:0] lcg_state = SEED;
    addr_t       burst_addr [$];
    axi_len_t    burst_len  [$];
    int          beat;
    logic        r_taken;      // beat accepted at the last rising edge
    addr_t       beat_addr;

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    initial begin
        ar_ready = 1'b0;
        r_valid  = 1'b0;
        r_data   = '0;
        r_resp   = RESP_OKAY;
        r_last   = 1'b0;
    end

    always @(posedge clk) begin
        r_taken <= !rst && r_valid && r_ready;
        if (!rst && ar_valid && ar_ready) begin
            burst_addr.push_back(ar_addr);
            burst_len.push_back(ar_len);
        end
    end

    always @(negedge clk) begin
        if (rst) begin
            ar_ready = 1'b0;
            r_valid  = 1'b0;
            r_last   = 1'b0;
            beat     = 0;
            burst_addr.delete();
            burst_len.delete();
        end else begin
            lcg_state = lcg_step(lcg_state);
            ar_ready  = lcg_state[20];     // address stall about half the time
            if (r_taken) begin
                r_valid = 1'b0;
                if (r_last) begin
                    void'(burst_addr.pop_front());
                    void'(burst_len.pop_front());
                    beat = 0;
                end else begin
                    beat++;
                end
            end
            // data stall on one cycle in four
            if (!r_valid && burst_addr.size() != 0 && lcg_state[27:26] != 2'b00) begin
                beat_addr = burst_addr[0] + addr_t'(beat * 4);
                r_valid   = 1'b1;
                r_data    = beat_addr ^ PATTERN;
                r_resp    = (beat_addr == ERR_ADDR) ? RESP_SLVERR : RESP_OKAY;
                r_last    = beat == int'(burst_len[0]);
            end
        end
    end

endmodule

`default_nettype wire

/* tb/tb_dma_read.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dma_read;

    import axi_pkg::*;
    import dma_pkg::*;

    localparam word_t PATTERN  = 32'ha5c3_5a3c;
    localparam addr_t ERR_ADDR = 32'h0000_4000;
    localparam int    FIFO_CAP = 64;

    typedef struct packed {
        addr_t addr;
        strb_t strb;
        logic  last;
    } exp_word_t;

    logic clk, rst, cmd_valid, cmd_ready, halt, busy, error, cmd_done;
    addr_t cmd_addr, ar_addr;
    byte_cnt_t cmd_bytes;
    logic ar_valid, ar_ready, r_valid, r_ready, r_last;
    axi_len_t ar_len;
    word_t r_data, out_data;
    axi_resp_t r_resp;
    logic out_valid, out_ready, out_last, pop_en, deliver, r_hs;
    strb_t out_strb;
    logic [8:0] out_free;

    logic [31:0] lcg = 32'h3d0b_1327;
    exp_word_t exp_q [$];
    axi_len_t len_q [$];
    exp_word_t head;
    logic head_valid, len_valid;
    axi_len_t head_len;
    int fill, r_cnt, done_cnt, cmd_cnt, errors, timeouts;

    assign deliver = out_valid && out_ready;
    assign r_hs    = r_valid && r_ready;

    dma_read #(.MAX_OUT(8), .QUEUE_DEPTH(4), .FREE_W(9)) dut (
        .clk(clk), .rst(rst), .cmd_valid(cmd_valid), .cmd_ready(cmd_ready),
        .cmd_addr(cmd_addr), .cmd_bytes(cmd_bytes), .ar_valid(ar_valid),
        .ar_ready(ar_ready), .ar_addr(ar_addr), .ar_len(ar_len), .r_valid(r_valid),
        .r_ready(r_ready), .r_data(r_data), .r_resp(r_resp), .r_last(r_last),
        .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data),
        .out_strb(out_strb), .out_last(out_last), .out_free(out_free),
        .halt(halt), .busy(busy), .error(error), .cmd_done(cmd_done)
    );

    axi_mem_model #(.SEED(32'h3d0b_1327), .PATTERN(PATTERN), .ERR_ADDR(ERR_ADDR)) mem (
        .clk(clk), .rst(rst), .ar_valid(ar_valid), .ar_ready(ar_ready),
        .ar_addr(ar_addr), .ar_len(ar_len), .r_valid(r_valid), .r_ready(r_ready),
        .r_data(r_data), .r_resp(r_resp), .r_last(r_last)
    );

    function automatic logic [31:0] next_rand();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg;
    endfunction

    function automatic word_t lane_mask(input strb_t s);
        return {{8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    task automatic count_error(input string msg);
        errors++;
        $display("%s", msg);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // downstream FIFO model, scoreboard pops and counters
    always @(posedge clk) begin
        if (rst) begin
            fill  <= 0;
            r_cnt <= 0;
            exp_q.delete();
            len_q.delete();
        end else begin
            if (deliver && exp_q.size() != 0) void'(exp_q.pop_front());
            if (ar_valid && ar_ready) len_q.push_back(ar_len);
            if (r_hs && r_last && len_q.size() != 0) void'(len_q.pop_front());
            if (r_hs) r_cnt <= r_last ? 0 : r_cnt + 1;
            fill <= fill + int'(deliver) - int'(pop_en && fill > 0);
            if (cmd_done) done_cnt++;
        end
    end

    always @(negedge clk) begin
        out_ready  = next_rand() % 4 != 0;
        pop_en     = next_rand() % 3 == 0;    // slow drain
        out_free   = 9'(FIFO_CAP - fill);
        head_valid = exp_q.size() != 0;
        if (head_valid) head = exp_q[0];
        len_valid = len_q.size() != 0;
        if (len_valid) head_len = len_q[0];
    end

    a_data: assert property (@(posedge clk) disable iff (rst)
        deliver && head_valid |-> ((out_data ^ head.addr ^ PATTERN) & lane_mask(out_strb)) == 0)
        else count_error($sformatf("Fail t=%0t out_data exp %h got %h", $time,
            head.addr ^ PATTERN, $sampled(out_data)));
    a_extra: assert property (@(posedge clk) disable iff (rst) deliver |-> head_valid)
        else count_error("output word delivered with no command pending");
    a_strb: assert property (@(posedge clk) disable iff (rst)
        deliver && head_valid |-> out_strb == head.strb)
        else count_error($sformatf("Fail t=%0t out_strb exp %h got %h", $time,
            head.strb, $sampled(out_strb)));
    a_last: assert property (@(posedge clk) disable iff (rst)
        deliver && head_valid |-> out_last == head.last)
        else count_error($sformatf("Fail t=%0t out_last exp %b got %b", $time,
            head.last, $sampled(out_last)));
    a_align: assert property (@(posedge clk) disable iff (rst)
        ar_valid |-> ar_addr[1:0] == 2'b00 && int'(ar_addr[5:2]) + int'(ar_len) <= 15)
        else count_error($sformatf("burst %h len %0d unaligned or crosses 64 bytes",
            $sampled(ar_addr), $sampled(ar_len)));
    a_beats: assert property (@(posedge clk) disable iff (rst)
        r_hs |-> len_valid && r_last == (r_cnt == int'(head_len)))
        else count_error($sformatf("Fail t=%0t r_last exp %b got %b", $time,
            $sampled(r_cnt) == int'(head_len), r_last));
    a_done: assert property (@(posedge clk) disable iff (rst)
        cmd_done |-> $past(deliver && out_last))
        else count_error("cmd_done pulsed without a final word");
    a_full: assert property (@(posedge clk) disable iff (rst) out_valid |-> fill < FIFO_CAP)
        else count_error("out_valid high while downstream FIFO is full");
    a_issue: assert property (@(posedge clk) disable iff (rst)
        $rose(ar_valid) |-> !$past(halt) && !$past(error))
        else count_error("ar_valid rose during halt or after error");
    a_sticky: assert property (@(posedge clk) disable iff (rst) error |=> error)
        else count_error("error cleared without reset");
    a_drop: assert property (@(posedge clk) disable iff (rst) error |-> !out_valid)
        else count_error("out_valid high after a bus error");

    task automatic expect_cmd(input addr_t a, input byte_cnt_t n);
        addr_t first_w, last_w, w, end_a;
        exp_word_t e;
        int b;
        first_w = a & ~32'h3;
        end_a   = a + addr_t'(n);       // one past the final byte
        last_w  = (end_a - 32'd1) & ~32'h3;
        for (w = first_w; w <= last_w; w += 32'd4) begin
            e.addr = w;
            for (b = 0; b < 4; b++) begin
                // lane enabled only for bytes inside the command
                e.strb[b] = w + addr_t'(b) >= a && w + addr_t'(b) < end_a;
            end
            e.last = w == last_w;
            exp_q.push_back(e);
        end
    endtask

    task automatic send_cmd(input addr_t a, input byte_cnt_t n);
        int t;
        t = 0;
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd_addr  = a;
        cmd_bytes = n;
        while (!cmd_ready && t < 2000) begin
            @(negedge clk);
            t++;
        end
        if (t >= 2000) begin
            timeouts++;
            $display("timeout waiting for cmd_ready");
        end else begin
            @(posedge clk);
            expect_cmd(a, n);
            cmd_cnt++;
        end
        @(negedge clk);
        cmd_valid = 1'b0;
    endtask

    task automatic wait_all_done();
        int t;
        t = 0;
        while (done_cnt != cmd_cnt && t < 20000) begin
            @(negedge clk);
            t++;
        end
        if (t >= 20000) begin
            timeouts++;
            $display("timeout waiting for all commands to finish");
        end
    endtask

    task automatic wait_idle();
        int t;
        t = 0;
        while (busy && t < 5000) begin
            @(negedge clk);
            t++;
        end
        if (t >= 5000) begin
            timeouts++;
            $display("timeout waiting for busy to fall");
        end
    endtask

    task automatic wait_flag(input bit want_error);
        int t;
        t = 0;
        while ((want_error ? !error : !ar_valid) && t < 5000) begin
            @(negedge clk);
            t++;
        end
        if (t >= 5000) begin
            timeouts++;
            $display("timeout waiting for %s", want_error ? "error" : "ar_valid");
        end
    endtask

    initial begin
        rst = 1'b1;
        cmd_valid = 1'b0;
        cmd_addr = '0;
        cmd_bytes = '0;
        halt = 1'b0;
        out_ready = 1'b0;
        out_free = 9'd64;
        {errors, timeouts, done_cnt, cmd_cnt} = '0;
        repeat (8) @(posedge clk);
        @(negedge clk) rst = 1'b0;
        if (ar_valid || out_valid || cmd_done || error || busy || !cmd_ready) begin
            errors++;
            $display("outputs not idle after reset");
        end
        send_cmd(32'h0000_0100, 12'd4);     // single word
        send_cmd(32'h0000_0203, 12'd1);
        send_cmd(32'h0000_03fe, 12'd5);     // crosses a 64-byte block
        send_cmd(32'h0000_0013, 12'd300);
        repeat (24) send_cmd(next_rand() & 32'h1fff, byte_cnt_t'(next_rand() % 300 + 1));
        wait_all_done();
        send_cmd(32'h0000_0800, 12'd300);
        wait_flag(1'b0);
        @(negedge clk) halt = 1'b1;
        wait_idle();
        repeat (20) @(negedge clk);
        halt = 1'b0;
        wait_all_done();
        if (done_cnt != cmd_cnt) begin
            errors++;
            $display("Fail t=%0t cmd_done count exp %0d got %0d", $time, cmd_cnt, done_cnt);
        end
        send_cmd(ERR_ADDR - 32'd8, 12'd32);
        wait_flag(1'b1);
        send_cmd(32'h0000_0400, 12'd64);    // stays queued behind the error
        wait_idle();
        repeat (10) @(negedge clk);
        rst = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        if (error) begin
            errors++;
            $display("Fail t=%0t error exp 0 got %b", $time, error);
        end
        $display("commands %0d, done pulses %0d, errors %0d, timeouts %0d",
            cmd_cnt, done_cnt, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* dma_read.f */
design/axi_pkg.sv
design/dma_pkg.sv
design/sync_fifo.sv
design/dma_cmd_split.sv
design/axi_burst_reader.sv
design/dma_read.sv
tb/axi_mem_model.sv
tb/tb_dma_read.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_dma_read
FILELIST  = dma_read.f
OBJ_DIR   = obj_dir
LOG       = run.log

.PHONY: run clean

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
